// ==== verilog/exs_pkg.sv ====
// Shared types and encodings for the integer execute slice
// Fields sit at the RISC-V base positions; rs3/funct2 occupy funct7
// addi and cmov are legal only with funct3 = F3_ADD, mulw only with F3_MULW
// An illegal retire carries rd and the illegal flag, all data fields zero
package exs_pkg;

    localparam logic [6:0] OPC_OP    = 7'b0110011; // add, sub, xor, and
    localparam logic [6:0] OPC_OPIMM = 7'b0010011; // addi
    localparam logic [6:0] OPC_WIDE  = 7'b0111011; // mulw
    localparam logic [6:0] OPC_CMOV  = 7'b0101011; // Three-source select

    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SUB  = 3'b001;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_MULW = 3'b011;

    // Three-source register view
    typedef struct packed {
        logic [4:0] rs3;
        logic [1:0] funct2;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r4_fmt_t;

    // Immediate view, imm12 covers rs3/funct2/rs2
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef union packed {
        r4_fmt_t r4;
        i_fmt_t  i;
    } iword_u;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_XOR,
        OP_AND,
        OP_ADDI,
        OP_MULW,
        OP_CMOV
    } alu_op_e;

    typedef struct packed {
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rs3;
        logic [4:0]  rd;
        logic [31:0] imm;     // Sign-extended, zero unless addi
        alu_op_e     op;
        logic        illegal;
        logic        wide;    // Legal mulw only
    } dec_t;

    typedef struct packed {
        logic        valid;
        logic        illegal;
        logic        wide;
        logic [4:0]  rd;
        logic [31:0] lo;
        logic [31:0] hi;      // Zero for narrow ops
    } retire_t;

endpackage

// ==== verilog/exs_decode.sv ====
// Combinational instruction decoder
// Unused source fields are forced to x0 so they read as zero
// mulw with an odd rd is flagged illegal since it cannot name a pair
`timescale 1ns/1ps

module exs_decode import exs_pkg::*; (
    input  iword_u instr,
    output dec_t   dec
);

    logic [6:0] opcode;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [2:0] funct3;

    assign opcode = instr.r4.opcode; // Same bits in both views
    assign rd     = instr.r4.rd;
    assign rs1    = instr.r4.rs1;
    assign funct3 = instr.r4.funct3;

    always_comb begin
        dec         = '0;
        dec.rd      = rd;
        dec.rs1     = rs1;
        dec.op      = OP_ADD;
        dec.illegal = 1'b0;

        case (opcode)
            OPC_OP: begin
                dec.rs2 = instr.r4.rs2;
                case (funct3)
                    F3_ADD:  dec.op = OP_ADD;
                    F3_SUB:  dec.op = OP_SUB;
                    F3_XOR:  dec.op = OP_XOR;
                    F3_AND:  dec.op = OP_AND;
                    default: dec.illegal = 1'b1;
                endcase
            end
            OPC_OPIMM: begin
                dec.op  = OP_ADDI;
                dec.imm = {{20{instr.i.imm12[11]}}, instr.i.imm12};
                if (funct3 != F3_ADD) begin
                    dec.illegal = 1'b1;
                end
            end
            OPC_WIDE: begin
                dec.rs2 = instr.r4.rs2;
                dec.op  = OP_MULW;
                if (funct3 != F3_MULW || rd[0]) begin
                    dec.illegal = 1'b1; // Odd rd has no pair
                end else begin
                    dec.wide = 1'b1;
                end
            end
            OPC_CMOV: begin
                dec.rs2 = instr.r4.rs2;
                dec.rs3 = instr.r4.rs3;
                dec.op  = OP_CMOV;
                if (funct3 != F3_ADD) begin
                    dec.illegal = 1'b1;
                end
            end
            default: begin
                dec.illegal = 1'b1; // Unknown opcode
            end
        endcase
    end

endmodule

// ==== verilog/exs_gprs.sv ====
// 32 x 32-bit register file split into even and odd banks of 16
// Three combinational read ports, one write port per clock
// A wide write fills an even/odd pair, the odd half from rd_wdata_hi
// x0 always reads zero; storage has no reset
`timescale 1ns/1ps

module exs_gprs (
    input  logic        g_clk,
    input  logic [4:0]  rs1_addr,
    input  logic [4:0]  rs2_addr,
    input  logic [4:0]  rs3_addr,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data,
    output logic [31:0] rs3_data,
    input  logic        rd_wen,
    input  logic        rd_wide,
    input  logic [4:0]  rd_addr,
    input  logic [31:0] rd_wdata,
    input  logic [31:0] rd_wdata_hi
);

    logic [31:0] bank_even [1:15]; // Row 0 is x0, not stored
    logic [31:0] bank_odd  [16];
    logic [31:0] even_view [16];

    logic [3:0]  wr_row;
    logic        wen_even;
    logic        wen_odd;
    logic [31:0] wdata_odd;

    always_comb begin
        even_view[0] = '0; // x0 tied low
        for (int i = 1; i < 16; i++) begin
            even_view[i] = bank_even[i];
        end
    end

    assign rs1_data = rs1_addr[0] ? bank_odd[rs1_addr[4:1]] : even_view[rs1_addr[4:1]];
    assign rs2_data = rs2_addr[0] ? bank_odd[rs2_addr[4:1]] : even_view[rs2_addr[4:1]];
    assign rs3_data = rs3_addr[0] ? bank_odd[rs3_addr[4:1]] : even_view[rs3_addr[4:1]];

    assign wr_row    = rd_addr[4:1];
    assign wen_even  = rd_wen && !rd_addr[0] && (wr_row != 4'd0); // Drops x0
    assign wen_odd   = rd_wen && (rd_addr[0] || rd_wide);
    assign wdata_odd = rd_wide ? rd_wdata_hi : rd_wdata;

    always_ff @(posedge g_clk) begin
        if (wen_even) begin
            bank_even[wr_row] <= rd_wdata;
        end
    end

    always_ff @(posedge g_clk) begin
        if (wen_odd) begin
            bank_odd[wr_row] <= wdata_odd;
        end
    end

    // x0 stays zero on every port, also right after a write aimed at it
    a_x0_zero: assert property (@(posedge g_clk)
        ((rs1_addr != 5'd0) || (rs1_data == 32'd0)) &&
        ((rs2_addr != 5'd0) || (rs2_data == 32'd0)) &&
        ((rs3_addr != 5'd0) || (rs3_data == 32'd0)))
        else $error("x0 read returned non-zero data");

endmodule

// ==== verilog/exs_exec.sv ====
// Execute unit: narrow ALU result or unsigned 64-bit product
// Drives the register write port in the cycle of instr_valid
// and registers the retire record at the same edge
// Illegal words write nothing and retire with zero data
`timescale 1ns/1ps

module exs_exec import exs_pkg::*; (
    input  logic        g_clk,
    input  logic        rst_n,
    input  logic        instr_valid,
    input  dec_t        dec,
    input  logic [31:0] rs1_data,
    input  logic [31:0] rs2_data,
    input  logic [31:0] rs3_data,
    output logic        rd_wen,
    output logic        rd_wide,
    output logic [4:0]  rd_addr,
    output logic [31:0] rd_wdata,
    output logic [31:0] rd_wdata_hi,
    output retire_t     retire
);

    logic        legal;
    logic [63:0] product;
    logic [31:0] result;
    logic [31:0] result_hi;
    retire_t     retire_nxt;

    assign legal   = !dec.illegal;
    assign product = {32'd0, rs1_data} * {32'd0, rs2_data}; // Unsigned

    always_comb begin
        case (dec.op)
            OP_ADD:  result = rs1_data + rs2_data;
            OP_SUB:  result = rs1_data - rs2_data;
            OP_XOR:  result = rs1_data ^ rs2_data;
            OP_AND:  result = rs1_data & rs2_data;
            OP_ADDI: result = rs1_data + dec.imm;
            OP_MULW: result = product[31:0];
            OP_CMOV: result = (rs2_data != 32'd0) ? rs1_data : rs3_data;
            default: result = '0;
        endcase
    end

    assign result_hi = dec.wide ? product[63:32] : 32'd0;

    // Write port
    assign rd_wen      = instr_valid && legal;
    assign rd_wide     = rd_wen && dec.wide;
    assign rd_addr     = dec.rd;
    assign rd_wdata    = result;
    assign rd_wdata_hi = result_hi;

    always_comb begin
        retire_nxt         = '0;
        retire_nxt.valid   = 1'b1;
        retire_nxt.illegal = dec.illegal;
        retire_nxt.rd      = dec.rd;
        if (legal) begin
            retire_nxt.wide = dec.wide;
            retire_nxt.lo   = result;
            retire_nxt.hi   = result_hi;
        end
    end

    always_ff @(posedge g_clk or negedge rst_n) begin
        if (!rst_n) begin
            retire <= '0;
        end else if (instr_valid) begin
            retire <= retire_nxt;
        end else begin
            retire <= '0; // Idle cycle, nothing retired
        end
    end

    // Decoder must never hand a wide write to an odd register
    a_wide_even: assert property (@(posedge g_clk) disable iff (!rst_n)
        rd_wide |-> !rd_addr[0])
        else $error("wide write to odd rd %0d", rd_addr);

    a_retire_on: assert property (@(posedge g_clk) disable iff (!rst_n)
        instr_valid |=> retire.valid)
        else $error("instruction did not retire");

    a_retire_off: assert property (@(posedge g_clk) disable iff (!rst_n)
        !instr_valid |=> !retire.valid)
        else $error("retire without instruction");

endmodule

// ==== verilog/exs_top.sv ====
// Top level of the execute slice
// One instruction per cycle on instr_valid, no stall or back-pressure
// Each valid word retires on the registered retire output one cycle later
`timescale 1ns/1ps

module exs_top import exs_pkg::*; (
    input  logic    g_clk,
    input  logic    rst_n,
    input  logic    instr_valid,
    input  iword_u  instr,
    output retire_t retire
);

    dec_t        dec;

    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [31:0] rs3_data;

    logic        rd_wen;
    logic        rd_wide;
    logic [4:0]  rd_addr;
    logic [31:0] rd_wdata;
    logic [31:0] rd_wdata_hi;

    exs_decode u_decode (
        .instr (instr),
        .dec   (dec)
    );

    exs_gprs u_gprs (
        .g_clk       (g_clk),
        .rs1_addr    (dec.rs1),
        .rs2_addr    (dec.rs2),
        .rs3_addr    (dec.rs3),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .rs3_data    (rs3_data),
        .rd_wen      (rd_wen),
        .rd_wide     (rd_wide),
        .rd_addr     (rd_addr),
        .rd_wdata    (rd_wdata),
        .rd_wdata_hi (rd_wdata_hi)
    );

    exs_exec u_exec (
        .g_clk       (g_clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .dec         (dec),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .rs3_data    (rs3_data),
        .rd_wen      (rd_wen),
        .rd_wide     (rd_wide),
        .rd_addr     (rd_addr),
        .rd_wdata    (rd_wdata),
        .rd_wdata_hi (rd_wdata_hi),
        .retire      (retire)
    );

endmodule

// ==== bench/exs_tb_model.sv ====
// Reference model of the execute slice, used by the testbench only
// Model registers start unknown and must be written before use
// Random numbers come from a 32-bit LCG seeded with 90
package exs_tb_model;
    import exs_pkg::*;

    logic [31:0] lcg_state = 32'd90;
    logic [31:0] model_regs [32]; // Index 0 never read

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state ^ (lcg_state >> 16); // Fold high bits into low ones
    endfunction

    function automatic logic [31:0] read_reg(input logic [4:0] idx);
        if (idx == 5'd0) begin
            return 32'd0;
        end
        return model_regs[idx];
    endfunction

    // Retire record that a word should produce with the current register state
    function automatic retire_t expected_retire(input logic [31:0] word);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] imm;
        logic [63:0] prod;
        retire_t     r;
        opc  = word[6:0];
        rd   = word[11:7];
        f3   = word[14:12];
        a    = read_reg(word[19:15]);
        b    = read_reg(word[24:20]);
        c    = read_reg(word[31:27]);
        imm  = {{20{word[31]}}, word[31:20]};
        prod = {32'd0, a} * {32'd0, b};
        r         = '0;
        r.valid   = 1'b1;
        r.rd      = rd;
        r.illegal = 1'b1; // Cleared by each legal form
        case (opc)
            OPC_OP: begin
                r.illegal = 1'b0;
                case (f3)
                    F3_ADD:  r.lo = a + b;
                    F3_SUB:  r.lo = a - b;
                    F3_XOR:  r.lo = a ^ b;
                    F3_AND:  r.lo = a & b;
                    default: r.illegal = 1'b1;
                endcase
            end
            OPC_OPIMM: begin
                if (f3 == F3_ADD) begin
                    r.illegal = 1'b0;
                    r.lo      = a + imm;
                end
            end
            OPC_WIDE: begin
                if (f3 == F3_MULW && !rd[0]) begin
                    r.illegal = 1'b0;
                    r.wide    = 1'b1;
                    r.lo      = prod[31:0];
                    r.hi      = prod[63:32];
                end
            end
            OPC_CMOV: begin
                if (f3 == F3_ADD) begin
                    r.illegal = 1'b0;
                    r.lo      = (b != 32'd0) ? a : c;
                end
            end
            default: r.illegal = 1'b1;
        endcase
        return r;
    endfunction

    function automatic void commit_retire(input retire_t r);
        if (r.illegal) begin
            return; // Nothing written
        end
        if (r.rd != 5'd0) begin
            model_regs[r.rd] = r.lo;
        end
        if (r.wide) begin
            model_regs[{r.rd[4:1], 1'b1}] = r.hi; // Odd half of the pair
        end
    endfunction

endpackage

// ==== bench/exs_tb.sv ====
// Testbench for the execute slice
// Inputs change on the falling clock edge and retire is sampled there too
// Each retire is compared with the model before the model commits it
`timescale 1ns/1ps

module exs_tb import exs_pkg::*, exs_tb_model::*; ();

    localparam int RETIRE_TIMEOUT = 8;
    localparam int NARROW_COUNT   = 300;
    localparam int MULW_COUNT     = 40;
    localparam int ILLEGAL_COUNT  = 40;
    localparam int GAP_COUNT      = 60;

    logic    g_clk;
    logic    rst_n;
    logic    instr_valid;
    iword_u  instr;
    retire_t retire;

    int checks;
    int errors;
    int timeouts;

    exs_top uut (
        .g_clk       (g_clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .retire      (retire)
    );

    always #4 g_clk = ~g_clk; // 8 ns period

    function automatic logic [31:0] enc_r4(input logic [4:0] rs3, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [6:0] opc);
        return {rs3, 2'b00, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [4:0] rd);
        return {imm, rs1, F3_ADD, rd, OPC_OPIMM};
    endfunction

    function automatic logic [4:0] pick_reg();
        logic [31:0] v;
        v = lcg_next();
        return v[31:27];
    endfunction

    function automatic int pick_below(input int n);
        logic [31:0] v;
        v = lcg_next();
        return int'(v[30:8]) % n;
    endfunction

    // Drives one word for one cycle and checks its retire record
    task automatic issue(input logic [31:0] word, input string name);
        retire_t exp;
        int      waited;
        exp         = expected_retire(word);
        instr       = word;
        instr_valid = 1'b1;
        @(negedge g_clk);
        instr_valid = 1'b0;
        waited      = 1;
        while (retire.valid !== 1'b1 && waited < RETIRE_TIMEOUT) begin
            @(negedge g_clk);
            waited++;
        end
        checks++;
        if (retire.valid !== 1'b1) begin
            timeouts++;
            $display("%s: no retire within %0d cycles", name, RETIRE_TIMEOUT);
        end else if (waited != 1) begin
            errors++;
            $display("%s: retire came %0d cycles after the strobe", name, waited);
        end else if (retire !== exp) begin
            errors++;
            $display("error %s: expected %h actual %h", name, exp, retire);
        end
        commit_retire(exp);
    endtask

    task automatic idle(input int cycles, input string name);
        repeat (cycles) begin
            @(negedge g_clk);
            checks++;
            if (retire.valid !== 1'b0) begin
                errors++;
                $display("error %s: expected valid 0 actual %b", name, retire.valid);
            end
        end
    endtask

    task automatic read_back(input logic [4:0] r, input string name);
        issue(enc_r4(5'd0, 5'd0, r, F3_ADD, 5'd0, OPC_OP), name); // add x0, r, x0
    endtask

    task automatic issue_narrow(inout logic [4:0] last_rd);
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] rs3;
        rd  = pick_reg();
        rs1 = (pick_below(2) == 0) ? last_rd : pick_reg(); // Often reads the last write
        rs2 = (pick_below(4) == 0) ? 5'd0 : pick_reg();    // Zero select for cmov
        rs3 = pick_reg();
        case (pick_below(6))
            0: issue(enc_r4(5'd0, rs2, rs1, F3_ADD, rd, OPC_OP), "add");
            1: issue(enc_r4(5'd0, rs2, rs1, F3_SUB, rd, OPC_OP), "sub");
            2: issue(enc_r4(5'd0, rs2, rs1, F3_XOR, rd, OPC_OP), "xor");
            3: issue(enc_r4(5'd0, rs2, rs1, F3_AND, rd, OPC_OP), "and");
            4: issue(enc_i(12'(lcg_next() >> 20), rs1, rd), "addi");
            default: issue(enc_r4(rs3, rs2, rs1, F3_ADD, rd, OPC_CMOV), "cmov");
        endcase
        last_rd = rd;
    endtask

    task automatic issue_mulw(input logic [4:0] rd);
        issue(enc_r4(5'd0, pick_reg(), pick_reg(), F3_MULW, rd, OPC_WIDE), "mulw");
        read_back(rd, "mulw lo read");
        read_back({rd[4:1], 1'b1}, "mulw hi read");
    endtask

    task automatic issue_illegal();
        logic [4:0] rd;
        logic [6:0] opc;
        logic [2:0] f3;
        rd  = pick_reg();
        opc = 7'(pick_below(128));
        f3  = 3'(pick_below(8));
        case (pick_below(3))
            0: begin
                rd[0] = 1'b1; // Odd pair base
                issue(enc_r4(5'd0, pick_reg(), pick_reg(), F3_MULW, rd, OPC_WIDE), "odd mulw");
            end
            1: begin
                if (opc inside {OPC_OP, OPC_OPIMM, OPC_WIDE, OPC_CMOV}) begin
                    opc[6] = ~opc[6];
                end
                issue(enc_r4(pick_reg(), pick_reg(), pick_reg(), f3, rd, opc), "bad opcode");
            end
            default: begin
                if (f3 inside {F3_ADD, F3_SUB, F3_XOR, F3_AND}) begin
                    f3 = 3'b010;
                end
                issue(enc_r4(5'd0, pick_reg(), pick_reg(), f3, rd, OPC_OP), "bad funct3");
            end
        endcase
        read_back(rd, "illegal read");
    endtask

    initial begin
        logic [4:0] last_rd;
        logic [4:0] rd;
        g_clk       = 1'b0;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        checks      = 0;
        errors      = 0;
        timeouts    = 0;
        last_rd     = 5'd1;

        idle(4, "reset");
        rst_n = 1'b1;
        idle(5, "after reset");

        // x0 first, its value retires but is not kept
        for (int k = 0; k < 32; k++) begin
            issue(enc_i(12'(lcg_next() >> 20), 5'd0, 5'(k)), "init addi");
        end
        read_back(5'd0, "x0 read");

        repeat (NARROW_COUNT) begin
            issue_narrow(last_rd);
        end

        repeat (MULW_COUNT) begin
            rd    = pick_reg();
            rd[0] = 1'b0;
            issue_mulw(rd);
        end
        issue_mulw(5'd0); // Only x1 changes
        read_back(5'd0, "x0 after mulw");

        repeat (ILLEGAL_COUNT) begin
            issue_illegal();
        end

        repeat (GAP_COUNT) begin
            idle(pick_below(5), "gap");
            if (pick_below(4) == 0) begin
                rd    = pick_reg();
                rd[0] = 1'b0;
                issue_mulw(rd);
            end else begin
                issue_narrow(last_rd);
            end
        end
        idle(3, "drain");

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
verilog/exs_pkg.sv
verilog/exs_decode.sv
verilog/exs_gprs.sv
verilog/exs_exec.sv
verilog/exs_top.sv
bench/exs_tb_model.sv
bench/exs_tb.sv

// ==== Bender.yml ====
package:
  name: exs

sources:
  - verilog/exs_pkg.sv
  - verilog/exs_decode.sv
  - verilog/exs_gprs.sv
  - verilog/exs_exec.sv
  - verilog/exs_top.sv
  - target: simulation
    files:
      - bench/exs_tb_model.sv
      - bench/exs_tb.sv
